// File: verilog/input_pkg.sv
// Control path package with PS/2 key word, joystick and port byte types plus key codes
package input_pkg;

	// ======================================================================
	// Types
	// ======================================================================

	// Toggle, pressed, extended, scan code
	typedef logic [10:0] ps2_key_t;
	typedef logic [7:0]  scan_code_t;
	typedef logic [7:0]  joy_t;        // Host joystick byte
	typedef logic [7:0]  port_byte_t;  // Active-high player port

	// Field positions in the key word
	localparam int key_toggle_bit  = 10;
	localparam int key_pressed_bit = 9;

	// Joystick bit positions, bits 5 to 7 unused
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;

	// ======================================================================
	// Scan codes, set 2
	// ======================================================================

	localparam scan_code_t key_up          = 8'h75;
	localparam scan_code_t key_down        = 8'h72;
	localparam scan_code_t key_left        = 8'h6b;
	localparam scan_code_t key_right       = 8'h74;
	localparam scan_code_t key_coin        = 8'h76;  // Escape
	localparam scan_code_t key_one_player  = 8'h05;  // F1
	localparam scan_code_t key_two_players = 8'h06;  // F2
	localparam scan_code_t key_fire        = 8'h29;  // Space

endpackage

// File: verilog/audio_pkg.sv
// Sound path package with channel and mix sample widths
package audio_pkg;

	// Raw sample from one sound channel of the game core
	typedef logic [7:0] sound_t;

	// Weighted sum a + 4*b, largest value 1275
	typedef logic [10:0] mix_t;

	// Default accumulator width of the one-bit DAC
	localparam int dac_width = 16;

endpackage

// File: verilog/button_if.sv
// Button bus carrying the held keyboard levels from the key decoder to the mapper
interface button_if;

	// Directions
	logic up;
	logic down;
	logic left;
	logic right;

	// Action and cabinet buttons
	logic fire;
	logic coin;
	logic one_player;
	logic two_players;

	modport source (
		output up, down, left, right,
		output fire, coin, one_player, two_players
	);

	modport sink (
		input up, down, left, right,
		input fire, coin, one_player, two_players
	);

endinterface

// File: verilog/key_decoder.sv
// Keyboard decoder turning PS/2 key events into held button levels
module key_decoder
	import input_pkg::*;
(
	input  logic     clk_24,
	input  logic     rst,
	input  ps2_key_t key,
	button_if.source btn
);

	logic       toggle_q;   // Toggle bit seen last cycle
	logic       key_event;
	logic       pressed;
	scan_code_t code;
	logic [7:0] levels;     // All buttons, for checking only

	assign pressed   = key[key_pressed_bit];
	assign code      = key[7:0];  // Extended flag not needed by the core
	assign key_event = key[key_toggle_bit] != toggle_q;

	// ======================================================================
	// Event detection
	// ======================================================================

	always_ff @(posedge clk_24) begin
		if (rst) begin
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= key[key_toggle_bit];
		end
	end

	// ======================================================================
	// Held levels
	// ======================================================================

	always_ff @(posedge clk_24) begin
		if (rst) begin
			btn.up          <= 1'b0;
			btn.down        <= 1'b0;
			btn.left        <= 1'b0;
			btn.right       <= 1'b0;
			btn.fire        <= 1'b0;
			btn.coin        <= 1'b0;
			btn.one_player  <= 1'b0;
			btn.two_players <= 1'b0;
		end else if (key_event) begin
			case (code)
				key_up:          btn.up          <= pressed;
				key_down:        btn.down        <= pressed;
				key_left:        btn.left        <= pressed;
				key_right:       btn.right       <= pressed;
				key_fire:        btn.fire        <= pressed;
				key_coin:        btn.coin        <= pressed;
				key_one_player:  btn.one_player  <= pressed;
				key_two_players: btn.two_players <= pressed;
				default: ;  // Other keys ignored
			endcase
		end
	end

	assign levels = {btn.up, btn.down, btn.left, btn.right,
		btn.fire, btn.coin, btn.one_player, btn.two_players};

	// A level only moves on the edge that sees a toggle change
	a_no_change_without_event: assert property (
		@(posedge clk_24) disable iff (rst)
		!key_event |=> $stable(levels)
	);

endmodule

// File: verilog/joy_capture.sv
// Joystick capture synchronizing both host bytes and merging the two players
module joy_capture
	import input_pkg::*;
(
	input  logic clk_24,
	input  logic rst,
	input  joy_t joystick_0,
	input  joy_t joystick_1,
	output joy_t joy
);

	joy_t joy0_s1;  // First synchronizer stage
	joy_t joy1_s1;

	// Stage one, straight from the I/O controller
	always_ff @(posedge clk_24) begin
		if (rst) begin
			joy0_s1 <= '0;
			joy1_s1 <= '0;
		end else begin
			joy0_s1 <= joystick_0;
			joy1_s1 <= joystick_1;
		end
	end

	// Stage two
	// Either player moves the same controls
	always_ff @(posedge clk_24) begin
		if (rst) begin
			joy <= '0;
		end else begin
			joy <= joy0_s1 | joy1_s1;
		end
	end

endmodule

// File: verilog/control_mapper.sv
// Control mapper merging keyboard and joystick, rotating and forming the port bytes
module control_mapper
	import input_pkg::*;
(
	input  logic       clk_24,
	input  logic       rst,
	button_if.sink     btn,
	input  joy_t       joy,
	input  logic       rotate,
	output port_byte_t p1_port,
	output port_byte_t p2_port
);

	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	// ======================================================================
	// Merge and rotation
	// ======================================================================

	always_comb begin
		if (rotate) begin
			// Cabinet turned by 90 degrees
			m_up    = btn.left  | joy[joy_left];
			m_down  = btn.right | joy[joy_right];
			m_left  = btn.down  | joy[joy_down];
			m_right = btn.up    | joy[joy_up];
		end else begin
			m_up    = btn.up    | joy[joy_up];
			m_down  = btn.down  | joy[joy_down];
			m_left  = btn.left  | joy[joy_left];
			m_right = btn.right | joy[joy_right];
		end
	end

	assign m_fire = btn.fire | joy[joy_fire];  // Not affected by rotation

	// ======================================================================
	// Port registers
	// ======================================================================

	always_ff @(posedge clk_24) begin
		if (rst) begin
			p1_port <= '0;
			p2_port <= '0;
		end else begin
			p1_port <= {btn.coin, 1'b0, m_left, m_right, m_fire, m_down, 1'b0, m_up};
			p2_port <= {6'b0, btn.two_players, btn.one_player};  // Start buttons only
		end
	end

endmodule

// File: verilog/audio_dac.sv
// Sound mixer and first-order sigma-delta one-bit DAC
module audio_dac
	import audio_pkg::*;
#(
	parameter int dac_width = audio_pkg::dac_width
) (
	input  logic   clk_24,
	input  logic   rst,
	input  sound_t sound_a,
	input  sound_t sound_b,
	output logic   audio_out
);

	// Left alignment of the mix in the DAC word
	localparam int align_shift = dac_width - $bits(mix_t);

	mix_t                 mix;
	logic [dac_width-1:0] dac_in;
	logic [dac_width:0]   acc;     // Top bit is the carry out

	// ======================================================================
	// Mixer
	// ======================================================================

	// Channel b is weighted by four
	assign mix = mix_t'(sound_a) + (mix_t'(sound_b) << 2);

	assign dac_in = dac_width'(mix) << align_shift;

	// ======================================================================
	// Modulator
	// ======================================================================

	// Carry density tracks dac_in / 2**dac_width
	always_ff @(posedge clk_24) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[dac_width-1:0]} + {1'b0, dac_in};
		end
	end

	assign audio_out = acc[dac_width];

	// Below half scale two carries never follow each other
	a_carry_spacing: assert property (
		@(posedge clk_24) disable iff (rst)
		audio_out && !dac_in[dac_width-1] && !$past(dac_in[dac_width-1]) |=> !audio_out
	);

endmodule

// File: verilog/cabinet_io.sv
// Cabinet I/O top level with keyboard and joystick control paths and the sound DAC
module cabinet_io
	import input_pkg::*;
	import audio_pkg::*;
#(
	parameter int dac_width = audio_pkg::dac_width
) (
	input  logic       clk_24,
	input  logic       rst,
	input  ps2_key_t   ps2_key,     // From the host I/O controller
	input  joy_t       joystick_0,
	input  joy_t       joystick_1,
	input  logic       rotate,      // OSD option
	input  sound_t     sound_a,
	input  sound_t     sound_b,
	output port_byte_t p1_port,
	output port_byte_t p2_port,
	output logic       audio_out
);

	joy_t joy;  // Both players merged

	button_if btn_bus ();

	// ======================================================================
	// Control path
	// ======================================================================

	key_decoder u_key_decoder (
		.clk_24 (clk_24),
		.rst    (rst),
		.key    (ps2_key),
		.btn    (btn_bus.source)
	);

	joy_capture u_joy_capture (
		.clk_24     (clk_24),
		.rst        (rst),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joy        (joy)
	);

	control_mapper u_control_mapper (
		.clk_24  (clk_24),
		.rst     (rst),
		.btn     (btn_bus.sink),
		.joy     (joy),
		.rotate  (rotate),
		.p1_port (p1_port),
		.p2_port (p2_port)
	);

	// ======================================================================
	// Sound path
	// ======================================================================

	// Same stream feeds both speaker channels on the board
	audio_dac #(
		.dac_width (dac_width)
	) u_audio_dac (
		.clk_24    (clk_24),
		.rst       (rst),
		.sound_a   (sound_a),
		.sound_b   (sound_b),
		.audio_out (audio_out)
	);

endmodule

// File: test/tb_cabinet_io.sv
// Directed testbench for the cabinet I/O block covering keys, joysticks, rotation and audio
module tb_cabinet_io
	import input_pkg::*;
	import audio_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Bit positions in the keyboard model vector
	localparam int btn_up    = 0;
	localparam int btn_down  = 1;
	localparam int btn_left  = 2;
	localparam int btn_right = 3;
	localparam int btn_fire  = 4;
	localparam int btn_coin  = 5;
	localparam int btn_one   = 6;
	localparam int btn_two   = 7;

	logic       clk_24;
	logic       rst;
	ps2_key_t   ps2_key;
	joy_t       joystick_0;
	joy_t       joystick_1;
	logic       rotate;
	sound_t     sound_a;
	sound_t     sound_b;
	port_byte_t p1_port;
	port_byte_t p2_port;
	logic       audio_out;

	logic [7:0]  kb;         // Held keys as the model sees them
	logic        toggle;     // Toggle bit of the last key word
	logic [31:0] rng_state;
	string       cur_test;
	int          errors;
	int          checks;
	int          tests;
	int          test_errors_start;

	cabinet_io #(
		.dac_width (16)
	) dut0 (
		.clk_24     (clk_24),
		.rst        (rst),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.sound_a    (sound_a),
		.sound_b    (sound_b),
		.p1_port    (p1_port),
		.p2_port    (p2_port),
		.audio_out  (audio_out)
	);

	always #4 clk_24 = ~clk_24;

	// ======================================================================
	// Reference model and helpers
	// ======================================================================

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int button_index(scan_code_t code);
		case (code)
			key_up:          return btn_up;
			key_down:        return btn_down;
			key_left:        return btn_left;
			key_right:       return btn_right;
			key_fire:        return btn_fire;
			key_coin:        return btn_coin;
			key_one_player:  return btn_one;
			key_two_players: return btn_two;
			default:         return -1;
		endcase
	endfunction

	function automatic port_byte_t expect_p1(logic [7:0] keys, joy_t j, logic rot);
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		up    = keys[btn_up]    | j[3];
		down  = keys[btn_down]  | j[2];
		left  = keys[btn_left]  | j[1];
		right = keys[btn_right] | j[0];
		fire  = keys[btn_fire]  | j[4];
		// Rotated: up from left, down from right, left from down, right from up
		if (rot)
			return {keys[btn_coin], 1'b0, down, up, fire, right, 1'b0, left};
		else
			return {keys[btn_coin], 1'b0, left, right, fire, down, 1'b0, up};
	endfunction

	function automatic port_byte_t expect_p2(logic [7:0] keys);
		return {6'b0, keys[btn_two], keys[btn_one]};
	endfunction

	// One clock, then 1 ns into the cycle where inputs change
	task automatic step();
		@(posedge clk_24);
		#1;
	endtask

	task automatic run_cycles(int n);
		for (int i = 0; i < n; i++)
			step();
	endtask

	task automatic send_key(scan_code_t code, logic pressed);
		int idx;
		idx = button_index(code);
		toggle = ~toggle;
		ps2_key = {toggle, pressed, 1'b0, code};
		if (idx >= 0)
			kb[idx] = pressed;
	endtask

	task automatic check_port(string what, port_byte_t expected, port_byte_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				cur_test, what, expected, actual);
		end
	endtask

	task automatic check_count(string what, int expected, int actual, int tol);
		checks++;
		if (actual > expected + tol || actual < expected - tol) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0d (+/-%0d), actual %0d",
				cur_test, what, expected, tol, actual);
		end
	endtask

	task automatic check_latency(string what, int expected, int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("CHECK FAILED %s %s latency: expected %0d, actual %0d",
				cur_test, what, expected, actual);
		end
	endtask

	task automatic check_ports(string what, joy_t j, logic rot);
		check_port({what, " p1"}, expect_p1(kb, j, rot), p1_port);
		check_port({what, " p2"}, expect_p2(kb), p2_port);
	endtask

	task automatic timeout_abort(string what);
		$display("Timeout in test %s: %s", cur_test, what);
		$display("Simulation failed");
		$finish;
	endtask

	// Count cycles until both ports hold the given bytes
	task automatic wait_ports(port_byte_t p1_exp, port_byte_t p2_exp, output int cycles);
		int n;
		n = 0;
		while ((p1_port !== p1_exp || p2_port !== p2_exp) && n < 16) begin
			step();
			n++;
		end
		if (p1_port !== p1_exp || p2_port !== p2_exp)
			timeout_abort("player ports never reached the expected bytes");
		else
			cycles = n;
	endtask

	task automatic begin_test(string name);
		cur_test = name;
		test_errors_start = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("Test %-10s %s, %0d errors", cur_test,
			(errors == test_errors_start) ? "ok" : "with errors", errors - test_errors_start);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_reset();
		int ones;
		begin_test("reset");
		ones = 0;
		for (int i = 0; i < 3; i++) begin
			step();
			if (audio_out !== 1'b0) ones++;
		end
		rst = 1'b0;
		for (int i = 0; i < 8; i++) begin
			step();
			if (audio_out !== 1'b0) ones++;
		end
		check_count("audio ones", 0, ones, 0);
		check_port("p1", 8'h00, p1_port);
		check_port("p2", 8'h00, p2_port);
		end_test();
	endtask

	task automatic test_keys();
		scan_code_t codes [8] = '{key_up, key_down, key_left, key_right,
			key_fire, key_coin, key_one_player, key_two_players};
		int cycles;
		begin_test("keys");
		foreach (codes[i]) begin
			send_key(codes[i], 1'b1);
			wait_ports(expect_p1(kb, 8'h00, 1'b0), expect_p2(kb), cycles);
			check_latency("press", 2, cycles);
			send_key(codes[i], 1'b0);
			wait_ports(expect_p1(kb, 8'h00, 1'b0), expect_p2(kb), cycles);
			check_latency("release", 2, cycles);
		end
		send_key(8'h1c, 1'b1);  // Letter A, not used by the core
		run_cycles(4);
		check_ports("unknown code", 8'h00, 1'b0);
		// Pressed bit and code change but the toggle stays
		ps2_key = {toggle, 1'b1, 1'b0, key_up};
		run_cycles(4);
		check_ports("no toggle", 8'h00, 1'b0);
		end_test();
	endtask

	task automatic test_joysticks();
		joy_t j0;
		joy_t j1;
		joy_t prev;
		begin_test("joysticks");
		send_key(key_fire, 1'b1);
		step();
		send_key(key_left, 1'b1);
		step();
		send_key(key_one_player, 1'b1);
		run_cycles(3);
		check_ports("held keys", 8'h00, 1'b0);
		prev = 8'h00;
		for (int i = 0; i < 32; i++) begin
			// Second half without keys, so joystick fire and left show alone
			if (i == 16) begin
				send_key(key_fire, 1'b0);
				step();
				send_key(key_left, 1'b0);
				step();
				send_key(key_one_player, 1'b0);
				run_cycles(3);
				check_ports("keys released", prev, 1'b0);
			end
			rng_state = xorshift32(rng_state);
			j0 = rng_state[7:0];
			j1 = rng_state[15:8];
			joystick_0 = j0;
			joystick_1 = j1;
			run_cycles(2);
			check_ports("before latency", prev, 1'b0);
			step();
			check_ports("after latency", j0 | j1, 1'b0);  // Players merged
			prev = j0 | j1;
		end
		joystick_0 = 8'h00;
		joystick_1 = 8'h00;
		run_cycles(3);
		check_ports("released", 8'h00, 1'b0);
		end_test();
	endtask

	task automatic test_rotation();
		scan_code_t dirs [4] = '{key_up, key_down, key_left, key_right};
		joy_t j;
		begin_test("rotation");
		foreach (dirs[i]) begin
			send_key(dirs[i], 1'b1);
			run_cycles(2);
			check_ports("key plain", 8'h00, 1'b0);
			rotate = 1'b1;
			step();
			check_ports("key rotated", 8'h00, 1'b1);
			rotate = 1'b0;
			step();
			check_ports("key back", 8'h00, 1'b0);
			send_key(dirs[i], 1'b0);
			run_cycles(2);
		end
		for (int b = 0; b < 4; b++) begin
			j = joy_t'(1 << b);
			if (b % 2 == 0)
				joystick_0 = j;
			else
				joystick_1 = j;  // Odd bits from player two
			run_cycles(3);
			check_ports("joy plain", j, 1'b0);
			rotate = 1'b1;
			step();
			check_ports("joy rotated", j, 1'b1);
			rotate = 1'b0;
			joystick_0 = 8'h00;
			joystick_1 = 8'h00;
			run_cycles(3);
		end
		end_test();
	endtask

	task automatic test_audio();
		int pairs [4][2] = '{'{0, 0}, '{255, 0}, '{0, 255}, '{255, 255}};
		int mix;
		int ones;
		int expected;
		begin_test("audio");
		foreach (pairs[i]) begin
			sound_a = sound_t'(pairs[i][0]);
			sound_b = sound_t'(pairs[i][1]);
			run_cycles(16);  // Settle
			ones = 0;
			for (int n = 0; n < 4096; n++) begin
				step();
				if (audio_out === 1'b1) ones++;
			end
			mix = pairs[i][0] + 4 * pairs[i][1];
			expected = (4096 * mix * 32) / 65536;
			check_count($sformatf("ones a=%0d b=%0d", pairs[i][0], pairs[i][1]),
				expected, ones, 1);
		end
		sound_a = 8'h00;
		sound_b = 8'h00;
		end_test();
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		clk_24     = 1'b0;
		rst        = 1'b1;
		ps2_key    = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate     = 1'b0;
		sound_a    = '0;
		sound_b    = '0;
		toggle     = 1'b0;
		kb         = '0;
		rng_state  = 32'h897c;
		errors     = 0;
		checks     = 0;
		tests      = 0;

		test_reset();
		test_keys();
		test_joysticks();
		test_rotation();
		test_audio();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: flist.f
verilog/input_pkg.sv
verilog/audio_pkg.sv
verilog/button_if.sv
verilog/key_decoder.sv
verilog/joy_capture.sv
verilog/control_mapper.sv
verilog/audio_dac.sv
verilog/cabinet_io.sv
test/tb_cabinet_io.sv

// File: Bender.yml
package:
  name: cabinet_io

sources:
  - files:
      - verilog/input_pkg.sv
      - verilog/audio_pkg.sv
      - verilog/button_if.sv
      - verilog/key_decoder.sv
      - verilog/joy_capture.sv
      - verilog/control_mapper.sv
      - verilog/audio_dac.sv
      - verilog/cabinet_io.sv
  - target: test
    files:
      - test/tb_cabinet_io.sv
